/* hw/xfer_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared encodings for the register-transfer core
//////////////////////////////////////////////////////////////////////

package xfer_pkg;

   // Command opcodes, one per host strobe
   typedef enum logic [2:0] {
      OP_NOP  = 3'd0,   // Nothing happens
      OP_LDI  = 3'd1,   // Dst <= immediate
      OP_MOV  = 3'd2,   // Dst <= src
      OP_ADD  = 3'd3,   // Dst <= dst + src
      OP_SUB  = 3'd4,   // Dst <= dst - src
      OP_AND  = 3'd5,   // Dst <= dst & src
      OP_XOR  = 3'd6,   // Dst <= dst ^ src
      OP_FLAG = 3'd7    // J-K command on carry, no write
   } xfer_op_e;

   // J-K carry commands in truth-table order {J,K}
   // Taken from imm[1:0] of an OP_FLAG command
   typedef enum logic [1:0] {
      JK_HOLD   = 2'd0, // J=0 K=0
      JK_CLEAR  = 2'd1, // J=0 K=1
      JK_SET    = 2'd2, // J=1 K=0
      JK_TOGGLE = 2'd3  // J=1 K=1
   } jk_cmd_e;

endpackage

`default_nettype wire

/* hw/ctrl_latch.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Control-word register, the 74x273 behind the microcode ROM
//////////////////////////////////////////////////////////////////////

module ctrl_latch import xfer_pkg::*; #(
   parameter int DATA_W   = 8,
   parameter int NUM_REGS = 4,
   localparam int SEL_W   = $clog2(NUM_REGS)
) (
   input  wire logic              clk,
   input  wire logic              rst,        // Active low, synchronous
   input  wire logic              cmd_strobe, // One cycle per command
   input  wire xfer_op_e          cmd_op,
   input  wire logic [SEL_W-1:0]  cmd_src,
   input  wire logic [SEL_W-1:0]  cmd_dst,
   input  wire logic [DATA_W-1:0] cmd_imm,
   output      logic [SEL_W-1:0]  rd_src_sel,
   output      logic [SEL_W-1:0]  rd_dst_sel,
   output      logic [SEL_W-1:0]  wr_sel,
   output      logic              wr_en,
   output      xfer_op_e          alu_op,
   output      logic [DATA_W-1:0] alu_imm,
   output      logic              flag_en,    // J-K command applies
   output      logic              carry_en,   // Carry loads from ALU
   output      jk_cmd_e           jk_cmd
);

   // Latched control word
   xfer_op_e          op_q;
   logic [SEL_W-1:0]  src_q;
   logic [SEL_W-1:0]  dst_q;
   logic [DATA_W-1:0] imm_q;

   //////////////////////////////////////////////////////////////////
   // Word register, NOP unless strobed
   //////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         op_q  <= OP_NOP;
         src_q <= '0;
         dst_q <= '0;
         imm_q <= '0;
      end else if (cmd_strobe) begin
         op_q  <= cmd_op;
         src_q <= cmd_src;
         dst_q <= cmd_dst;
         imm_q <= cmd_imm;
      end else begin
         op_q  <= OP_NOP; // Idle cycle loads an empty word
         src_q <= '0;
         dst_q <= '0;
         imm_q <= '0;
      end
   end

   // Steering straight from the word
   assign rd_src_sel = src_q;
   assign rd_dst_sel = dst_q;   // Dst is also the left ALU operand
   assign wr_sel     = dst_q;   // Written back to the same register
   assign alu_op     = op_q;
   assign alu_imm    = imm_q;

   //////////////////////////////////////////////////////////////////
   // Opcode decode into datapath enables
   //////////////////////////////////////////////////////////////////

   always_comb begin
      wr_en    = 1'b0;
      flag_en  = 1'b0;
      carry_en = 1'b0;
      jk_cmd   = JK_HOLD;
      case (op_q)
         OP_LDI, OP_MOV, OP_AND, OP_XOR: wr_en = 1'b1;
         OP_ADD, OP_SUB: begin
            wr_en    = 1'b1;
            carry_en = 1'b1;            // Carry or no-borrow
         end
         OP_FLAG: begin
            flag_en = 1'b1;
            jk_cmd  = jk_cmd_e'(imm_q[1:0]); // J,K from low imm bits
         end
         default: ;                     // OP_NOP
      endcase
   end

endmodule

`default_nettype wire

/* hw/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// General register bank, one 74x574 per register
//////////////////////////////////////////////////////////////////////

module reg_bank #(
   parameter int DATA_W   = 8,
   parameter int NUM_REGS = 4,
   localparam int SEL_W   = $clog2(NUM_REGS)
) (
   input  wire logic              clk,
   input  wire logic              rst,        // Active low, synchronous
   input  wire logic [SEL_W-1:0]  rd_src_sel, // Source operand select
   input  wire logic [SEL_W-1:0]  rd_dst_sel, // Destination operand select
   input  wire logic              wr_en,
   input  wire logic [SEL_W-1:0]  wr_sel,
   input  wire logic [DATA_W-1:0] wr_data,
   output      logic [DATA_W-1:0] src_data,
   output      logic [DATA_W-1:0] dst_data
);

   // Register storage
   logic [DATA_W-1:0] regs [NUM_REGS];

   // One-hot load strobes, like a 74x138 on the clock enables
   logic [NUM_REGS-1:0] wr_dec;

   //////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////

   always_comb begin
      wr_dec = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         if (wr_en && (wr_sel == SEL_W'(i))) begin
            wr_dec[i] = 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////

   // Each register loads on its own strobe
   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;              // Bank comes up clear
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            if (wr_dec[i]) begin
               regs[i] <= wr_data;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////////////////////

   // Select muxes take the place of the /OE bus drivers
   // No bypass, a write lands before the next word reads
   always_comb begin
      src_data = '0;
      dst_data = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         if (rd_src_sel == SEL_W'(i)) begin
            src_data = regs[i];
         end
         if (rd_dst_sel == SEL_W'(i)) begin
            dst_data = regs[i];
         end
      end
   end

endmodule

`default_nettype wire

/* hw/xfer_alu.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Combinational 8-bit ALU
//////////////////////////////////////////////////////////////////////

module xfer_alu import xfer_pkg::*; #(
   parameter int DATA_W = 8
) (
   input  wire xfer_op_e          alu_op,
   input  wire logic [DATA_W-1:0] src_data,
   input  wire logic [DATA_W-1:0] dst_data,
   input  wire logic [DATA_W-1:0] alu_imm,
   output      logic [DATA_W-1:0] alu_result,
   output      logic              alu_carry
);

   // One bit wider to catch carry and borrow
   logic [DATA_W:0] sum;
   logic [DATA_W:0] diff;

   // Widened adders in place of a pair of 74x283
   assign sum  = {1'b0, dst_data} + {1'b0, src_data};
   assign diff = {1'b0, dst_data} - {1'b0, src_data}; // MSB set on borrow

   //////////////////////////////////////////////////////////////////
   // Function select
   //////////////////////////////////////////////////////////////////

   always_comb begin
      alu_result = '0;
      alu_carry  = 1'b0;
      case (alu_op)
         OP_LDI: alu_result = alu_imm;
         OP_MOV: alu_result = src_data;
         OP_ADD: begin
            alu_result = sum[DATA_W-1:0];
            alu_carry  = sum[DATA_W];   // Carry out
         end
         OP_SUB: begin
            alu_result = diff[DATA_W-1:0];
            alu_carry  = ~diff[DATA_W]; // No borrow when dst >= src
         end
         OP_AND: alu_result = dst_data & src_data;
         OP_XOR: alu_result = dst_data ^ src_data;
         default: begin
            // NOP and FLAG give zero
            alu_result = '0;
            alu_carry  = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/status_reg.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Flags and result register
//////////////////////////////////////////////////////////////////////

module status_reg import xfer_pkg::*; #(
   parameter int DATA_W = 8
) (
   input  wire logic              clk,
   input  wire logic              rst,        // Active low, synchronous
   input  wire logic              flag_en,    // OP_FLAG in flight
   input  wire logic              carry_en,   // ADD or SUB in flight
   input  wire jk_cmd_e           jk_cmd,
   input  wire logic              wr_en,      // Register write in flight
   input  wire logic [DATA_W-1:0] alu_result,
   input  wire logic              alu_carry,
   output      logic              res_valid,
   output      logic [DATA_W-1:0] res_data,
   output      logic              carry,
   output      logic              zero
);

   //////////////////////////////////////////////////////////////////
   // Carry, a 74x112 half with a parallel load
   //////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         carry <= 1'b0;
      end else if (carry_en) begin
         carry <= alu_carry;            // Arithmetic load
      end else if (flag_en) begin
         case (jk_cmd)
            JK_CLEAR:  carry <= 1'b0;
            JK_SET:    carry <= 1'b1;
            JK_TOGGLE: carry <= ~carry;
            default:   carry <= carry;  // Hold
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////
   // Zero flag
   //////////////////////////////////////////////////////////////////

   // Follows the value written back
   always_ff @(posedge clk) begin
      if (!rst) begin
         zero <= 1'b0;
      end else if (wr_en) begin
         zero <= (alu_result == '0);
      end
   end

   //////////////////////////////////////////////////////////////////
   // Result register and valid strobe
   //////////////////////////////////////////////////////////////////

   // Every non-NOP either writes or is a flag command
   always_ff @(posedge clk) begin
      if (!rst) begin
         res_valid <= 1'b0;
         res_data  <= '0;
      end else begin
         res_valid <= wr_en | flag_en;  // High for one cycle
         if (wr_en || flag_en) begin
            res_data <= alu_result;     // Zero for OP_FLAG
         end
      end
   end

endmodule

`default_nettype wire

/* hw/xfer_top.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Register-transfer core, top level
//////////////////////////////////////////////////////////////////////

module xfer_top import xfer_pkg::*; #(
   parameter int DATA_W   = 8,
   parameter int NUM_REGS = 4,
   localparam int SEL_W   = $clog2(NUM_REGS)
) (
   input  wire logic              clk,
   input  wire logic              rst,        // Active low, synchronous
   input  wire logic              cmd_strobe,
   input  wire xfer_op_e          cmd_op,
   input  wire logic [SEL_W-1:0]  cmd_src,
   input  wire logic [SEL_W-1:0]  cmd_dst,
   input  wire logic [DATA_W-1:0] cmd_imm,
   output      logic              res_valid,  // Two edges after strobe
   output      logic [DATA_W-1:0] res_data,
   output      logic              carry,
   output      logic              zero
);

   // Steering from the control word
   logic [SEL_W-1:0]  rd_src_sel;
   logic [SEL_W-1:0]  rd_dst_sel;
   logic [SEL_W-1:0]  wr_sel;
   logic              wr_en;
   xfer_op_e          alu_op;
   logic [DATA_W-1:0] alu_imm;
   logic              flag_en;
   logic              carry_en;
   jk_cmd_e           jk_cmd;

   // Datapath
   logic [DATA_W-1:0] src_data;
   logic [DATA_W-1:0] dst_data;
   logic [DATA_W-1:0] alu_result;     // Also the write-back data
   logic              alu_carry;

   ctrl_latch #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) ctrl_latch_i (
      .clk, .rst, .cmd_strobe, .cmd_op, .cmd_src, .cmd_dst, .cmd_imm,
      .rd_src_sel, .rd_dst_sel, .wr_sel, .wr_en, .alu_op, .alu_imm,
      .flag_en, .carry_en, .jk_cmd
   );

   reg_bank #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) reg_bank_i (
      .clk, .rst, .rd_src_sel, .rd_dst_sel, .wr_en, .wr_sel,
      .wr_data (alu_result),
      .src_data, .dst_data
   );

   xfer_alu #(.DATA_W(DATA_W)) xfer_alu_i (
      .alu_op, .src_data, .dst_data, .alu_imm, .alu_result, .alu_carry
   );

   status_reg #(.DATA_W(DATA_W)) status_reg_i (
      .clk, .rst, .flag_en, .carry_en, .jk_cmd, .wr_en, .alu_result,
      .alu_carry, .res_valid, .res_data, .carry, .zero
   );

endmodule

`default_nettype wire

/* testbench/xfer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xfer_tb import xfer_pkg::*; ();

   localparam int DATA_W      = 8;
   localparam int NUM_REGS    = 4;
   localparam int SEL_W       = $clog2(NUM_REGS);
   localparam int DRAIN_LIMIT = 20;     // Cycles allowed for results to land

   logic              clk;
   logic              rst;
   logic              cmd_strobe;
   xfer_op_e          cmd_op;
   logic [SEL_W-1:0]  cmd_src;
   logic [SEL_W-1:0]  cmd_dst;
   logic [DATA_W-1:0] cmd_imm;
   logic              res_valid;
   logic [DATA_W-1:0] res_data;
   logic              carry;
   logic              zero;

   // Reference model state
   logic [DATA_W-1:0] shadow [NUM_REGS];
   logic              m_carry;
   logic              m_zero;
   logic [DATA_W+2:0] exp_q [$];       // {valid, data, carry, zero}
   logic              exp_valid;
   logic [DATA_W-1:0] exp_data;
   logic              exp_carry;
   logic              exp_zero;

   logic chk_on;                        // Checks armed once reset is done
   int   sent_cnt;                      // Non-NOP commands strobed
   int   seen_cnt;                      // res_valid pulses observed
   int   errors;
   int   tests;

   xfer_top #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) xfer_top_i (
      .clk, .rst, .cmd_strobe, .cmd_op, .cmd_src, .cmd_dst, .cmd_imm,
      .res_valid, .res_data, .carry, .zero
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;            // 4 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model with one queue entry per edge
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin : model
      logic [DATA_W-1:0] val;
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] s;
      logic              wr;
      logic              vld;
      if (!rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
         end
         m_carry = 1'b0;
         m_zero  = 1'b0;
         exp_q.delete();
         exp_q.push_back('0);           // Idle word behind reset
         {exp_valid, exp_data, exp_carry, exp_zero} = '0;
      end else begin
         val = '0;
         wr  = 1'b0;
         vld = 1'b0;
         d   = shadow[cmd_dst];
         s   = shadow[cmd_src];
         if (cmd_strobe && cmd_op != OP_NOP) begin
            vld = 1'b1;
            sent_cnt++;
            case (cmd_op)
               OP_LDI: begin val = cmd_imm; wr = 1'b1; end
               OP_MOV: begin val = s; wr = 1'b1; end
               OP_ADD: begin
                  val     = d + s;
                  m_carry = (int'(d) + int'(s)) >= (1 << DATA_W); // Sum overflows
                  wr      = 1'b1;
               end
               OP_SUB: begin
                  val     = d - s;
                  m_carry = (d >= s);   // Set when nothing borrowed
                  wr      = 1'b1;
               end
               OP_AND: begin val = d & s; wr = 1'b1; end
               OP_XOR: begin val = d ^ s; wr = 1'b1; end
               default: begin
                  // Flag command in J-K order from imm[1:0]
                  case (cmd_imm[1:0])
                     2'd1:    m_carry = 1'b0;
                     2'd2:    m_carry = 1'b1;
                     2'd3:    m_carry = ~m_carry;
                     default: m_carry = m_carry;
                  endcase
               end
            endcase
         end
         if (wr) begin
            shadow[cmd_dst] = val;
            m_zero          = (val == '0);
         end
         {exp_valid, exp_data, exp_carry, exp_zero} = exp_q.pop_front();
         exp_q.push_back({vld, val, m_carry, m_zero});
      end
   end

   always @(negedge clk) begin
      if (chk_on && res_valid === 1'b1) begin
         seen_cnt++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output checks at mid-cycle where everything has settled
   //////////////////////////////////////////////////////////////////////

   assert property (@(negedge clk) disable iff (!chk_on) res_valid === exp_valid)
   else begin
      $display("FAIL %0t: res_valid %b, expected %b", $time, res_valid, exp_valid);
      errors++;
   end

   assert property (@(negedge clk) disable iff (!chk_on)
                    exp_valid |-> res_data === exp_data)
   else begin
      $display("FAIL %0t: res_data %h, expected %h", $time, res_data, exp_data);
      errors++;
   end

   assert property (@(negedge clk) disable iff (!chk_on) carry === exp_carry)
   else begin
      $display("FAIL %0t: carry %b, expected %b", $time, carry, exp_carry);
      errors++;
   end

   assert property (@(negedge clk) disable iff (!chk_on) zero === exp_zero)
   else begin
      $display("FAIL %0t: zero %b, expected %b", $time, zero, exp_zero);
      errors++;
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [DATA_W-1:0] random_byte();
      return DATA_W'($urandom);
   endfunction

   function automatic int random_reg();
      return int'($urandom_range(0, NUM_REGS - 1));
   endfunction

   // One strobed command driven 1 ns after the edge
   task automatic send_cmd(input xfer_op_e op, input int src, input int dst,
                           input int imm);
      @(posedge clk);
      #1;
      cmd_strobe = 1'b1;
      cmd_op     = op;
      cmd_src    = SEL_W'(src);
      cmd_dst    = SEL_W'(dst);
      cmd_imm    = DATA_W'(imm);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      cmd_strobe = 1'b0;
      cmd_op     = OP_NOP;
      cmd_src    = '0;
      cmd_dst    = '0;
      cmd_imm    = '0;
   endtask

   // Stop strobing and wait until every result has come out
   task automatic drain_results(input string name);
      int cycles;
      cycles = 0;
      idle_cycle();
      while (seen_cnt != sent_cnt && cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (seen_cnt != sent_cnt) begin
         $display("Timeout in %s: %0d results expected but only %0d arrived",
                  name, sent_cnt, seen_cnt);
         $display("Testbench failed");
         $finish;
      end else begin
         repeat (2) idle_cycle();       // Valid must drop again
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      drain_results(name);
      tests++;
      $display("test %-12s done, %0d errors", name, errors - err_start);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      int err_start;
      err_start = errors;
      repeat (4) idle_cycle();          // Quiet outputs after reset
      for (int r = 0; r < NUM_REGS; r++) begin
         send_cmd(OP_MOV, r, (r + 1) % NUM_REGS, 0);
      end
      finish_test("reset", err_start);
   endtask

   task automatic test_load_move();
      int                err_start;
      logic [DATA_W-1:0] val;
      err_start = errors;
      for (int s = 0; s < NUM_REGS; s++) begin
         for (int d = 0; d < NUM_REGS; d++) begin
            if (s != d) begin
               val = ((s + d) % 3 == 0) ? '0 : random_byte();
               send_cmd(OP_LDI, 0, s, val);
               send_cmd(OP_MOV, s, d, random_byte()); // Imm ignored
            end
         end
      end
      finish_test("load_move", err_start);
   endtask

   task automatic test_arith();
      int err_start;
      int s;
      int d;
      err_start = errors;
      send_cmd(OP_LDI, 0, 0, 255);
      send_cmd(OP_LDI, 0, 1, 1);
      send_cmd(OP_ADD, 1, 0, 0);        // Wraps to 0 with carry
      send_cmd(OP_LDI, 0, 2, 77);
      send_cmd(OP_LDI, 0, 3, 77);
      send_cmd(OP_SUB, 3, 2, 0);        // Equal operands
      send_cmd(OP_LDI, 0, 2, 5);
      send_cmd(OP_SUB, 3, 2, 0);        // Borrow
      repeat (24) begin
         d = random_reg();
         s = random_reg();
         send_cmd(OP_LDI, 0, d, random_byte());
         if (s != d) send_cmd(OP_LDI, 0, s, random_byte());
         send_cmd(($urandom_range(0, 1) == 1) ? OP_ADD : OP_SUB, s, d, 0);
      end
      finish_test("arith", err_start);
   endtask

   task automatic test_logic();
      int err_start;
      int s;
      int d;
      err_start = errors;
      send_cmd(OP_FLAG, 0, 0, 2);       // Carry set so logic ops must keep it
      repeat (16) begin
         d = random_reg();
         s = (d + 1 + int'($urandom_range(0, NUM_REGS - 2))) % NUM_REGS;
         send_cmd(OP_LDI, 0, d, random_byte());
         send_cmd(OP_LDI, 0, s, random_byte());
         send_cmd(($urandom_range(0, 1) == 1) ? OP_AND : OP_XOR, s, d, 0);
      end
      send_cmd(OP_LDI, 0, 1, 8'h5a);
      send_cmd(OP_XOR, 1, 1, 0);        // Self XOR clears
      send_cmd(OP_FLAG, 0, 0, 1);
      send_cmd(OP_LDI, 0, 2, 8'hf0);
      send_cmd(OP_AND, 2, 2, 0);
      finish_test("logic", err_start);
   endtask

   task automatic test_flag();
      int err_start;
      err_start = errors;
      send_cmd(OP_LDI, 0, 0, 8'h3c);
      send_cmd(OP_FLAG, 0, 0, 8'h02);   // Set
      send_cmd(OP_FLAG, 0, 0, 8'h00);   // Hold
      send_cmd(OP_FLAG, 0, 0, 8'hf1);   // Clear with upper bits ignored
      send_cmd(OP_FLAG, 0, 0, 8'h03);   // Toggle
      send_cmd(OP_FLAG, 0, 0, 8'ha7);   // Toggle again
      send_cmd(OP_FLAG, 0, 0, 8'h04);
      send_cmd(OP_LDI, 0, 3, 8'h00);    // zero = 1 now
      send_cmd(OP_FLAG, 0, 0, 8'h03);
      finish_test("flag", err_start);
   endtask

   task automatic test_back_to_back();
      int err_start;
      int prev_dst;
      int dst;
      err_start = errors;
      prev_dst = 0;
      for (int n = 0; n < 40; n++) begin
         dst = random_reg();
         if (n % 8 == 7) begin
            send_cmd(OP_NOP, prev_dst, dst, random_byte()); // Gap
         end else begin
            send_cmd(xfer_op_e'(3'($urandom_range(0, 7))), prev_dst, dst,
                     random_byte());
         end
         prev_dst = dst;
      end
      finish_test("back2back", err_start);
   endtask

   initial begin
      rst        = 1'b0;
      cmd_strobe = 1'b0;
      cmd_op     = OP_NOP;
      cmd_src    = '0;
      cmd_dst    = '0;
      cmd_imm    = '0;
      chk_on     = 1'b0;
      sent_cnt   = 0;
      seen_cnt   = 0;
      errors     = 0;
      tests      = 0;
      void'($urandom(57));
      repeat (10) @(posedge clk);
      #1;
      rst    = 1'b1;
      chk_on = 1'b1;
      test_reset();
      test_load_move();
      test_arith();
      test_logic();
      test_flag();
      test_back_to_back();
      $display("%0d tests, %0d results checked, %0d errors", tests, seen_cnt, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
hw/xfer_pkg.sv
hw/ctrl_latch.sv
hw/reg_bank.sv
hw/xfer_alu.sv
hw/status_reg.sv
hw/xfer_top.sv
testbench/xfer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the register-transfer core testbench with Verilator and run it.
# Exit status is nonzero when the build or run breaks or a check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module xfer_tb \
   -Mdir obj_dir -o xfer_tb_sim > "$LOG" 2>&1 \
   && ./obj_dir/xfer_tb_sim >> "$LOG" 2>&1 \
   || { cat "$LOG"; echo "Build or simulation error, see $LOG"; exit 1; }

cat "$LOG"

# Verdict comes from the log text
grep -q "Testbench failed" "$LOG" \
   && { echo "Simulation reported errors, see $LOG"; exit 1; }

echo "Simulation clean"
exit 0
